// File: common/lookup_pkg.sv
`default_nettype none

package lookup_pkg;

	localparam int X_W    = 24;             // latitude and table x
	localparam int Y_W    = 32;             // table y and result
	localparam int ADDR_W = 7;              // 128 table entries
	localparam int NUM_W  = X_W + Y_W + 1;  // interpolation numerator

	typedef logic [X_W-1:0]    coord_t;
	typedef logic [Y_W-1:0]    value_t;
	typedef logic [ADDR_W-1:0] table_addr_t;
	typedef logic [NUM_W-1:0]  numerator_t;

	// control phases of one lookup
	typedef enum logic [2:0] {
		ph_idle,
		ph_scan,
		ph_term0,   // y0 * (x1 - x0)
		ph_term1,   // (y1 - y0) * (lat - x0)
		ph_divide,
		ph_done
	} lookup_phase_e;

endpackage

`default_nettype wire

// File: common/segment_if.sv
`timescale 1ns/1ps
`default_nettype none

// bracketing pair of table entries, lower one in x0/y0
interface segment_if import lookup_pkg::*; ();

	coord_t x0;
	coord_t x1;
	value_t y0;
	value_t y1;

	modport producer (output x0, x1, y0, y1);
	modport consumer (input x0, x1, y0, y1);

endinterface

`default_nettype wire

// File: interp/table_scan.sv
`timescale 1ns/1ps
`default_nettype none

module table_scan import lookup_pkg::*; (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               scan_en,
	input  coord_t             lat,
	output table_addr_t        cos_addr,
	input  logic [X_W+Y_W-1:0] cos_data,
	output logic               found,
	segment_if.producer        seg
);

	table_addr_t addr;
	coord_t      entry_x;
	value_t      entry_y;
	logic        past_lat;
	logic        last_entry;

	assign entry_x = cos_data[X_W+Y_W-1:Y_W];
	assign entry_y = cos_data[Y_W-1:0];

	// entry 0 is never the upper bound
	assign past_lat   = (addr != '0) && (entry_x > lat);
	assign last_entry = (addr == '1);
	assign found      = scan_en && (past_lat || last_entry);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			addr <= '0;
		end else if (scan_en && !found) begin
			addr <= addr + 1'b1;
		end else begin
			addr <= '0;
		end
	end

	assign cos_addr = addr;

	// sliding window, frozen once scan_en drops
	always_ff @(posedge clk) begin
		if (scan_en) begin
			seg.x0 <= seg.x1;
			seg.y0 <= seg.y1;
			seg.x1 <= entry_x;
			seg.y1 <= entry_y;
		end
	end

endmodule

`default_nettype wire

// File: interp/interp_mac.sv
`timescale 1ns/1ps
`default_nettype none

module interp_mac import lookup_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  coord_t      lat,
	segment_if.consumer seg,
	input  logic        term_sel,
	input  logic        mul_capture,
	output numerator_t  numerator,
	output coord_t      span
);

	logic [Y_W:0] dy;   // y1 - y0, two's complement
	coord_t       dx;   // lat - x0
	numerator_t   mul_a;
	coord_t       mul_b;
	numerator_t   product;
	numerator_t   num_q;

	assign span = seg.x1 - seg.x0;
	assign dx   = lat - seg.x0;
	assign dy   = {1'b0, seg.y1} - {1'b0, seg.y0};

	// operand select for the one shared multiplier
	always_comb begin
		if (term_sel) begin
			mul_a = {{(NUM_W-Y_W-1){dy[Y_W]}}, dy};   // sign extended, cosine may fall
			mul_b = dx;
		end else begin
			mul_a = {{(NUM_W-Y_W){1'b0}}, seg.y0};
			mul_b = span;
		end
	end

	// operands stay put for MUL_CYCLES, so this path is multicycle
	assign product = mul_a * {{(NUM_W-X_W){1'b0}}, mul_b};

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			num_q <= '0;
		end else if (mul_capture) begin
			if (term_sel)
				num_q <= num_q + product;   // wraps mod 2^NUM_W
			else
				num_q <= product;
		end
	end

	assign numerator = num_q;

endmodule

`default_nettype wire

// File: interp/restoring_divider.sv
`timescale 1ns/1ps
`default_nettype none

module restoring_divider import lookup_pkg::*; #(
	parameter int DIV_BITS_PER_CYCLE = 4
) (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       start,
	input  numerator_t dividend,
	input  coord_t     divisor,
	output value_t     quotient,
	output logic       done
);

	localparam int ITER = (NUM_W + DIV_BITS_PER_CYCLE - 1) / DIV_BITS_PER_CYCLE;
	localparam int Q_W  = ITER * DIV_BITS_PER_CYCLE;   // dividend padded with leading zeros
	localparam int IT_W = $clog2(ITER + 1);
	localparam int R_W  = X_W + 1;

	logic [IT_W-1:0] iter_left;
	logic [IT_W-1:0] left_after;
	logic            active;
	logic [R_W-1:0]  rem_q, rem_nx;
	logic [Q_W-1:0]  dq_q, dq_nx;   // dividend out at the top, quotient in at the bottom
	coord_t          dsr_q, dsr;

	assign active     = start || (iter_left != '0);
	assign left_after = start ? IT_W'(ITER - 1) : iter_left - 1'b1;
	assign dsr        = start ? divisor : dsr_q;

	// DIV_BITS_PER_CYCLE compare-subtract-shift steps, first batch runs in the start cycle
	always_comb begin
		logic [R_W-1:0] trial;
		rem_nx = start ? '0 : rem_q;
		dq_nx  = start ? Q_W'(dividend) : dq_q;
		for (int i = 0; i < DIV_BITS_PER_CYCLE; i++) begin
			trial = {rem_nx[X_W-1:0], dq_nx[Q_W-1]};
			if (trial >= {1'b0, dsr}) begin
				rem_nx = trial - {1'b0, dsr};
				dq_nx  = {dq_nx[Q_W-2:0], 1'b1};
			end else begin
				rem_nx = trial;
				dq_nx  = {dq_nx[Q_W-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active) begin
			rem_q <= rem_nx;
			dq_q  <= dq_nx;
		end
		if (start) dsr_q <= divisor;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			iter_left <= '0;
			done      <= 1'b0;
			quotient  <= '0;
		end else begin
			done <= 1'b0;
			if (active) begin
				iter_left <= left_after;
				if (left_after == '0) begin
					done     <= 1'b1;
					quotient <= dq_nx[Y_W-1:0];   // held until the next division ends
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/lookup_control.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_control import lookup_pkg::*; #(
	parameter int MUL_CYCLES = 5
) (
	input  logic   clk,
	input  logic   reset_n,
	input  logic   den,
	input  coord_t lat_in,
	input  logic   found,
	input  logic   div_done,
	output coord_t lat_q,
	output logic   scan_en,
	output logic   term_sel,
	output logic   mul_capture,
	output logic   div_start,
	output logic   valid
);

	localparam int CNT_W = $clog2(MUL_CYCLES + 1);
	localparam logic [CNT_W-1:0] MUL_LAST = CNT_W'(MUL_CYCLES - 1);

	lookup_phase_e    phase;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			phase <= ph_idle;
			cnt   <= '0;
		end else begin
			case (phase)
				ph_idle: if (den) phase <= ph_scan;   // den while busy falls through
				ph_scan: begin
					cnt <= '0;
					if (found) phase <= ph_term0;
				end
				ph_term0, ph_term1: begin
					if (cnt == MUL_LAST) begin
						cnt   <= '0;
						phase <= (phase == ph_term0) ? ph_term1 : ph_divide;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ph_divide: begin
					cnt <= CNT_W'(1);   // start already issued
					if (div_done) phase <= ph_done;
				end
				ph_done: phase <= ph_idle;
				default: phase <= ph_idle;
			endcase
		end
	end

	// latitude only taken when a new lookup starts
	always_ff @(posedge clk) begin
		if (phase == ph_idle && den) lat_q <= lat_in;
	end

	assign scan_en     = (phase == ph_scan);
	assign term_sel    = (phase == ph_term1);
	assign mul_capture = (phase == ph_term0 || phase == ph_term1) && (cnt == MUL_LAST);
	assign div_start   = (phase == ph_divide) && (cnt == '0);
	assign valid       = (phase == ph_done);   // one cycle after div_done

endmodule

`default_nettype wire

// File: source/cos_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module cos_lookup import lookup_pkg::*; #(
	parameter int MUL_CYCLES         = 5,
	parameter int DIV_BITS_PER_CYCLE = 4
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               den,
	input  coord_t             lat_in,
	output table_addr_t        cos_addr,
	input  logic [X_W+Y_W-1:0] cos_data,   // {x, y}
	output logic               valid,
	output value_t             cos_out
);

	coord_t     lat_q;
	logic       scan_en;
	logic       term_sel;
	logic       mul_capture;
	logic       div_start;
	logic       found;
	logic       div_done;
	numerator_t numerator;
	coord_t     span;

	segment_if seg_bus ();

	lookup_control #(.MUL_CYCLES(MUL_CYCLES)) u_control (
		.clk         (clk),
		.reset_n     (reset_n),
		.den         (den),
		.lat_in      (lat_in),
		.found       (found),
		.div_done    (div_done),
		.lat_q       (lat_q),
		.scan_en     (scan_en),
		.term_sel    (term_sel),
		.mul_capture (mul_capture),
		.div_start   (div_start),
		.valid       (valid)
	);

	table_scan u_scan (
		.clk      (clk),
		.reset_n  (reset_n),
		.scan_en  (scan_en),
		.lat      (lat_q),
		.cos_addr (cos_addr),
		.cos_data (cos_data),
		.found    (found),
		.seg      (seg_bus.producer)
	);

	interp_mac u_mac (
		.clk         (clk),
		.reset_n     (reset_n),
		.lat         (lat_q),
		.seg         (seg_bus.consumer),
		.term_sel    (term_sel),
		.mul_capture (mul_capture),
		.numerator   (numerator),
		.span        (span)
	);

	// quotient register doubles as the result output
	restoring_divider #(.DIV_BITS_PER_CYCLE(DIV_BITS_PER_CYCLE)) u_div (
		.clk      (clk),
		.reset_n  (reset_n),
		.start    (div_start),
		.dividend (numerator),
		.divisor  (span),
		.quotient (cos_out),
		.done     (div_done)
	);

endmodule

`default_nettype wire

// File: tests/tb_table.svh
// cosine table model, included inside the testbench modules

localparam int     TABLE_DEPTH = 128;
localparam coord_t LAT_MIN     = 24'd0;          // x of entry 0
localparam coord_t LAT_MAX     = 24'd15836772;   // x of entry 127 minus one

// x rises with a small quadratic term so segment widths differ
function automatic coord_t table_x(input int addr);
	return 24'(addr * 120000 + addr * addr * 37);
endfunction

// falling values, steeper toward the end of the table
function automatic value_t table_y(input int addr);
	return 32'(32'hf000_0000 - addr * addr * 16411 - addr * 977);
endfunction

// File: tests/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import lookup_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        den,
	input  coord_t      lat_in,
	input  table_addr_t cos_addr,
	input  logic        valid,
	input  value_t      cos_out,
	output int          lookup_count,
	output int          error_count
);

	`include "tb_table.svh"

	string  test_name = "startup";
	int     test_lookups;
	int     test_errors;
	logic   busy;
	logic   seen_den;
	coord_t pending_lat;
	value_t pending_exp;

	// first entry above lat bounds the segment, then straight-line interpolation
	function automatic value_t expected_cos(input coord_t lat);
		int     k;
		longint x0;
		longint x1;
		longint y0;
		longint y1;
		longint num;
		k = 1;
		while (k < TABLE_DEPTH - 1 && table_x(k) <= lat)
			k++;
		x0  = longint'(table_x(k - 1));
		x1  = longint'(table_x(k));
		y0  = longint'(table_y(k - 1));
		y1  = longint'(table_y(k));
		num = y0 * (x1 - x0) + (y1 - y0) * (longint'(lat) - x0);   // y1 - y0 is negative here
		return 32'(num / (x1 - x0));
	endfunction

	task automatic begin_test(input string name);
		test_name    = name;
		test_lookups = 0;
		test_errors  = 0;
	endtask

	task automatic finish_test(input int expected_lookups);
		@(negedge clk);   // lets the compare process finish the last edge
		if (test_lookups != expected_lookups) begin
			$display("test %0s saw %0d results but %0d lookups were started",
				test_name, test_lookups, expected_lookups);
			test_errors++;
			error_count++;
		end
		$display("test %0s: %0d lookups, %0d errors", test_name, test_lookups, test_errors);
	endtask

	initial begin
		lookup_count = 0;
		error_count  = 0;
	end

	always @(posedge clk) begin
		if (!reset_n) begin
			busy     = 1'b0;
			seen_den = 1'b0;
		end else begin
			if (valid && !busy) begin
				$display("valid pulse with no lookup in flight during test %0s", test_name);
				test_errors++;
				error_count++;
			end else if (valid) begin
				test_lookups++;
				lookup_count++;
				if (cos_out !== pending_exp) begin
					$display("error %0s: lat %0d expected %0d actual %0d",
						test_name, pending_lat, pending_exp, cos_out);
					test_errors++;
					error_count++;
				end
			end else if (!seen_den && cos_out !== '0) begin
				$display("error %0s: cos_out before first den expected 0 actual %0d",
					test_name, cos_out);
				test_errors++;
				error_count++;
			end
			// table address parks at entry 0 between lookups
			if (!busy && cos_addr !== '0) begin
				$display("error %0s: cos_addr while idle expected 0 actual %0d",
					test_name, cos_addr);
				test_errors++;
				error_count++;
			end
			// den on the done cycle is still ignored, so busy clears last
			if (den && !busy) begin
				pending_lat = lat_in;
				pending_exp = expected_cos(lat_in);
				busy        = 1'b1;
				seen_den    = 1'b1;
			end
			if (valid)
				busy = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import lookup_pkg::*; ();

	`include "tb_table.svh"

	localparam int VALID_TIMEOUT = 1000;   // cycles, longest lookup is under 200

	logic               clk = 1'b0;
	logic               reset_n;
	logic               den;
	coord_t             lat_in;
	table_addr_t        cos_addr;
	logic [X_W+Y_W-1:0] cos_data;
	logic               valid;
	value_t             cos_out;
	logic [X_W+Y_W-1:0] rom [TABLE_DEPTH];
	integer             seed;
	logic               aborted;
	int                 lookup_count;
	int                 error_count;

	always #10 clk = ~clk;

	assign cos_data = rom[cos_addr];   // combinational ROM

	cos_lookup #(.MUL_CYCLES(5), .DIV_BITS_PER_CYCLE(4)) DUT (
		.clk      (clk),
		.reset_n  (reset_n),
		.den      (den),
		.lat_in   (lat_in),
		.cos_addr (cos_addr),
		.cos_data (cos_data),
		.valid    (valid),
		.cos_out  (cos_out)
	);

	tb_checker chk (
		.clk          (clk),
		.reset_n      (reset_n),
		.den          (den),
		.lat_in       (lat_in),
		.cos_addr     (cos_addr),
		.valid        (valid),
		.cos_out      (cos_out),
		.lookup_count (lookup_count),
		.error_count  (error_count)
	);

	// point inside segment k, eighths of the way up
	function automatic coord_t segment_point(input int k, input int eighths);
		return 24'(int'(table_x(k)) + (int'(table_x(k + 1)) - int'(table_x(k))) * eighths / 8);
	endfunction

	task automatic start_lookup(input coord_t lat);
		@(posedge clk);
		den    <= 1'b1;
		lat_in <= lat;
		@(posedge clk);
		den    <= 1'b0;
	endtask

	task automatic wait_valid();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (valid !== 1'b1 && cycles < VALID_TIMEOUT);
		if (valid !== 1'b1) begin
			$display("timeout, no valid pulse within %0d cycles", VALID_TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	task automatic run_lookup(input coord_t lat);
		if (!aborted) begin
			start_lookup(lat);
			wait_valid();
		end
	endtask

	initial begin
		int i;
		seed    = 32'hbcba_4eb2;
		aborted = 1'b0;
		reset_n = 1'b0;
		den     = 1'b0;
		lat_in  = '0;
		for (i = 0; i < TABLE_DEPTH; i++)
			rom[i] = {table_x(i), table_y(i)};
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;

		chk.begin_test("reset_idle");
		repeat (20) @(posedge clk);
		chk.finish_test(0);

		chk.begin_test("mid_segment");
		run_lookup(segment_point(40, 4));
		run_lookup(segment_point(7, 3));
		chk.finish_test(2);

		chk.begin_test("exact_entry");
		run_lookup(table_x(25));
		run_lookup(table_x(90));
		chk.finish_test(2);

		chk.begin_test("range_edges");   // shortest and longest scans
		run_lookup(LAT_MIN);
		run_lookup(segment_point(0, 5));
		run_lookup(segment_point(126, 2));
		run_lookup(LAT_MAX);
		chk.finish_test(4);

		chk.begin_test("busy_den");
		start_lookup(segment_point(60, 1));
		repeat (3) @(posedge clk);
		start_lookup(segment_point(10, 6));   // lands in the scan phase
		wait_valid();
		repeat (400) @(posedge clk);          // window for a stray second result
		chk.finish_test(1);

		chk.begin_test("random");
		for (i = 0; i < 200 && !aborted; i++)
			run_lookup(24'($unsigned($random(seed)) % (32'(LAT_MAX) + 32'd1)));
		chk.finish_test(200);

		$display("tests 6, lookups %0d, errors %0d", lookup_count, error_count);
		if (!aborted && error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tests
common/lookup_pkg.sv
common/segment_if.sv
interp/table_scan.sv
interp/interp_mac.sv
interp/restoring_divider.sv
source/lookup_control.sv
source/cos_lookup.sv
tests/tb_checker.sv
tests/tb_top.sv
